//--- hdl/hdc_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_config.svh"

module hdc_apb_regs (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [`HDC_APB_ADDR_WIDTH-1:0] paddr,
    input  wire [31:0]                    pwdata,
    input  wire                           enc_busy,
    input  wire                           search_busy,
    input  wire hdc_core_pkg::hv_t        enc_value,
    input  wire hdc_core_pkg::class_idx_t best_class,
    input  wire hdc_core_pkg::distance_t  best_distance,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          item_we,
    output hdc_core_pkg::item_idx_t       item_waddr,
    output hdc_core_pkg::hv_t             item_wdata,
    output logic                          enc_start,
    output hdc_bus_pkg::hdc_op_e          enc_op,
    output hdc_core_pkg::item_idx_t       cmd_arg,
    output hdc_core_pkg::shift_t          cmd_shift,
    output logic                          search_start
);
    import hdc_bus_pkg::*;
    import hdc_core_pkg::*;

    hv_t         item_data_q;
    logic [31:0] arg_q;
    shift_t      shift_q;
    logic        busy;
    logic        wr_cmd;
    logic        xfer_done;
    logic        addr_ok;
    logic        addr_ro;
    hdc_op_e     cmd_op;
    logic        cmd_ok;
    logic        cmd_fire;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transfer decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign busy   = enc_busy | search_busy;
    assign wr_cmd = psel & pwrite & (paddr == REG_CMD);
    // a command write stalls in access until both engines are idle.
    assign pready    = ~(wr_cmd & busy);
    assign xfer_done = psel & penable & pready;

    always_comb begin
        addr_ok = 1'b1;
        addr_ro = 1'b0;
        case (paddr)
            REG_ITEM_DATA, REG_ARG, REG_SHIFT, REG_CMD: addr_ro = 1'b0;
            REG_STATUS, REG_ENC, REG_RESULT:            addr_ro = 1'b1;
            default:                                    addr_ok = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command check and issue.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign cmd_op = hdc_op_e'(pwdata[2:0]);

    // upper opcode bits must be clear and arg must fit the target.
    always_comb begin
        case (cmd_op)
            OP_GEN_ITEM, OP_LOAD, OP_BIND: cmd_ok = arg_q < 32'(`HDC_ITEM_DEPTH);
            OP_STORE_CLASS:                cmd_ok = arg_q < 32'(`HDC_CLASS_COUNT);
            OP_CLEAR, OP_QUERY:            cmd_ok = 1'b1;
            default:                       cmd_ok = 1'b0;
        endcase
        cmd_ok = cmd_ok & (pwdata[31:3] == '0);
    end

    assign cmd_fire = xfer_done & wr_cmd & cmd_ok;
    assign pslverr  = xfer_done & (~addr_ok | (pwrite & addr_ro) | (wr_cmd & ~cmd_ok));

    // strobes live for the single completing cycle.
    assign item_we      = cmd_fire & (cmd_op == OP_GEN_ITEM);
    assign search_start = cmd_fire & (cmd_op == OP_QUERY);
    assign enc_start    = cmd_fire & ((cmd_op == OP_CLEAR) | (cmd_op == OP_LOAD) |
                                      (cmd_op == OP_BIND) | (cmd_op == OP_STORE_CLASS));

    assign enc_op     = cmd_op;
    assign cmd_arg    = arg_q[$bits(item_idx_t)-1:0];
    assign cmd_shift  = shift_q;
    assign item_waddr = arg_q[$bits(item_idx_t)-1:0];
    assign item_wdata = item_data_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            item_data_q <= '0;
            arg_q       <= '0;
            shift_q     <= '0;
        end else if (xfer_done && pwrite) begin
            case (paddr)
                REG_ITEM_DATA: item_data_q <= pwdata;
                REG_ARG:       arg_q       <= pwdata;
                REG_SHIFT:     shift_q     <= pwdata[4:0];
                default:       ;
            endcase
        end
    end

    // cmd reads back as zero.
    always_comb begin
        case (paddr)
            REG_ITEM_DATA: prdata = item_data_q;
            REG_ARG:       prdata = arg_q;
            REG_SHIFT:     prdata = {27'b0, shift_q};
            REG_STATUS:    prdata = {31'b0, busy};
            REG_ENC:       prdata = enc_value;
            REG_RESULT:    prdata = {18'b0, best_distance, 6'b0, best_class};
            default:       prdata = '0;
        endcase
    end

    // back-pressure keeps the two engines from running at the same time.
    assert property (@(posedge clk) disable iff (!rst_n) !(enc_busy && search_busy));

endmodule

`default_nettype wire

//--- hdl/hdc_assoc_search.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_config.svh"

module hdc_assoc_search (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           proto_we,
    input  wire hdc_core_pkg::class_idx_t proto_idx,
    input  wire hdc_core_pkg::hv_t        enc_value,
    input  wire                           start,
    output logic                          busy,
    output hdc_core_pkg::class_idx_t      best_class,
    output hdc_core_pkg::distance_t       best_distance
);
    import hdc_core_pkg::*;

    hv_t           protos [`HDC_CLASS_COUNT];
    search_state_e state;
    class_idx_t    scan_idx;
    class_idx_t    min_class;
    distance_t     min_dist;
    hv_t           diff;
    distance_t     cur_dist;
    logic          take;
    logic          last;
    distance_t     next_dist;
    class_idx_t    next_class;

    assign busy = (state == SRCH_SCAN);
    assign last = (scan_idx == class_idx_t'(`HDC_CLASS_COUNT - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // prototype store.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // empty classes read as all zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < `HDC_CLASS_COUNT; c++) begin
                protos[c] <= '0;
            end
        end else if (proto_we) begin
            protos[proto_idx] <= enc_value;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hamming distance and compare.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        diff     = enc_value ^ protos[scan_idx];
        cur_dist = '0;
        for (int b = 0; b < `HDC_HV_WIDTH; b++) begin
            cur_dist = cur_dist + distance_t'(diff[b]);
        end
        // strict less-than keeps the lower index on a tie.
        take       = (scan_idx == '0) || (cur_dist < min_dist);
        next_dist  = take ? cur_dist : min_dist;
        next_class = take ? scan_idx : min_class;
    end

    // one class per cycle, result lands after the last one.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= SRCH_IDLE;
            scan_idx      <= '0;
            min_class     <= '0;
            min_dist      <= '0;
            best_class    <= '0;
            best_distance <= '0;
        end else begin
            case (state)
                SRCH_IDLE: begin
                    if (start) begin
                        state    <= SRCH_SCAN;
                        scan_idx <= '0;
                    end
                end
                SRCH_SCAN: begin
                    min_dist  <= next_dist;
                    min_class <= next_class;
                    scan_idx  <= scan_idx + class_idx_t'(1);
                    if (last) begin
                        state         <= SRCH_IDLE;
                        best_class    <= next_class;
                        best_distance <= next_dist;
                    end
                end
                default: state <= SRCH_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        best_distance <= distance_t'(`HDC_HV_WIDTH));

endmodule

`default_nettype wire

//--- hdl/hdc_bus_pkg.sv
`default_nettype none

`include "hdc_config.svh"

package hdc_bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word aligned byte addresses.
    typedef enum logic [`HDC_APB_ADDR_WIDTH-1:0] {
        REG_ITEM_DATA = 8'h00,  // value for the next item write.
        REG_ARG       = 8'h04,  // symbol or class index.
        REG_SHIFT     = 8'h08,  // rotate amount.
        REG_CMD       = 8'h0C,  // write issues a command.
        REG_STATUS    = 8'h10,  // bit 0 busy.
        REG_ENC       = 8'h14,  // accumulator, read only.
        REG_RESULT    = 8'h18   // class and distance, read only.
    } reg_addr_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command opcodes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // values 6 and 7 are unused and rejected.
    typedef enum logic [2:0] {
        OP_GEN_ITEM    = 3'd0,
        OP_CLEAR       = 3'd1,
        OP_LOAD        = 3'd2,
        OP_BIND        = 3'd3,
        OP_STORE_CLASS = 3'd4,
        OP_QUERY       = 3'd5
    } hdc_op_e;

endpackage

`default_nettype wire

//--- hdl/hdc_config.svh
`ifndef HDC_CONFIG_SVH
`define HDC_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hypervector geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// bits per hypervector, one bus word.
`define HDC_HV_WIDTH 32

// number of symbols the item memory can hold.
`define HDC_ITEM_DEPTH 256

// number of class prototypes in the search block.
`define HDC_CLASS_COUNT 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// byte address width of the APB port.
`define HDC_APB_ADDR_WIDTH 8

`endif

//--- hdl/hdc_core_pkg.sv
`default_nettype none

`include "hdc_config.svh"

package hdc_core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`HDC_HV_WIDTH-1:0] hv_t;
    typedef logic [$clog2(`HDC_ITEM_DEPTH)-1:0] item_idx_t;
    typedef logic [$clog2(`HDC_CLASS_COUNT)-1:0] class_idx_t;
    // one extra value so a full mismatch fits.
    typedef logic [$clog2(`HDC_HV_WIDTH+1)-1:0] distance_t;
    typedef logic [$clog2(`HDC_HV_WIDTH)-1:0] shift_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machines.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // fetch waits on the item memory read, apply updates the accumulator.
    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_FETCH,
        ENC_APPLY
    } enc_state_e;

    typedef enum logic {
        SRCH_IDLE,
        SRCH_SCAN
    } search_state_e;

endpackage

`default_nettype wire

//--- hdl/hdc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_config.svh"

module hdc_encoder (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start,
    input  wire hdc_bus_pkg::hdc_op_e     op,
    input  wire hdc_core_pkg::item_idx_t  arg,
    input  wire hdc_core_pkg::shift_t     shift,
    input  wire hdc_core_pkg::hv_t        item_rdata,
    output hdc_core_pkg::item_idx_t       item_raddr,
    output logic                          busy,
    output hdc_core_pkg::hv_t             enc_value,
    output logic                          proto_we,
    output hdc_core_pkg::class_idx_t      proto_idx
);
    import hdc_bus_pkg::*;
    import hdc_core_pkg::*;

    enc_state_e                   state;
    hv_t                          acc;
    logic                         bind_q;
    item_idx_t                    arg_q;
    shift_t                       shift_q;
    logic [2*`HDC_HV_WIDTH-1:0]   doubled;
    hv_t                          rotated;

    // rotate right by shifting a doubled copy.
    assign doubled = {item_rdata, item_rdata} >> shift_q;
    assign rotated = doubled[`HDC_HV_WIDTH-1:0];

    assign item_raddr = arg_q;
    assign busy       = (state != ENC_IDLE);
    assign enc_value  = acc;

    // store needs no fetch, the search block copies acc directly.
    assign proto_we  = start & (op == OP_STORE_CLASS);
    assign proto_idx = arg[$bits(class_idx_t)-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command fsm.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENC_IDLE;
            acc   <= '0;
        end else begin
            case (state)
                ENC_IDLE: begin
                    if (start && op == OP_CLEAR) begin
                        acc <= '0;
                    end else if (start && (op == OP_LOAD || op == OP_BIND)) begin
                        state <= ENC_FETCH;
                    end
                end
                // read address is out, data arrives next cycle.
                ENC_FETCH: state <= ENC_APPLY;
                ENC_APPLY: begin
                    acc   <= bind_q ? (acc ^ rotated) : item_rdata;
                    state <= ENC_IDLE;
                end
                default: state <= ENC_IDLE;
            endcase
        end
    end

    // command arguments, captured on issue.
    always_ff @(posedge clk) begin
        if (start) begin
            arg_q   <= arg;
            shift_q <= shift;
            bind_q  <= (op == OP_BIND);
        end
    end

    // back-pressure upstream keeps new commands out while busy.
    assert property (@(posedge clk) disable iff (!rst_n) start |-> state == ENC_IDLE);

endmodule

`default_nettype wire

//--- hdl/hdc_item_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_config.svh"

module hdc_item_memory (
    input  wire                          clk,
    input  wire                          we,
    input  wire hdc_core_pkg::item_idx_t waddr,
    input  wire hdc_core_pkg::hv_t       wdata,
    input  wire hdc_core_pkg::item_idx_t raddr,
    output hdc_core_pkg::hv_t            rdata
);
    import hdc_core_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one hypervector per symbol.
    // contents are undefined until the host writes them.
    hv_t mem [`HDC_ITEM_DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ports.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // host write port.
    // one word per strobe, driven by the register block.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port for the encoder.
    // address in one cycle, data out on the next.
    // no enable, the encoder holds raddr steady while it waits.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    // reads and writes never target the same word in one cycle,
    // since a write command waits for the encoder to go idle.

endmodule

`default_nettype wire

//--- hdl/hdc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_config.svh"

module hdc_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [`HDC_APB_ADDR_WIDTH-1:0] paddr,
    input  wire [31:0]                    pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr
);
    import hdc_bus_pkg::*;
    import hdc_core_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // interconnect.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic       item_we;
    item_idx_t  item_waddr;
    hv_t        item_wdata;
    item_idx_t  item_raddr;
    hv_t        item_rdata;
    logic       enc_start;
    hdc_op_e    enc_op;
    item_idx_t  cmd_arg;
    shift_t     cmd_shift;
    logic       enc_busy;
    hv_t        enc_value;
    logic       proto_we;
    class_idx_t proto_idx;
    logic       search_start;
    logic       search_busy;
    class_idx_t best_class;
    distance_t  best_distance;

    // host side.
    hdc_apb_regs u_regs (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .enc_busy, .search_busy, .enc_value, .best_class, .best_distance,
        .prdata, .pready, .pslverr, .item_we, .item_waddr, .item_wdata,
        .enc_start, .enc_op, .cmd_arg, .cmd_shift, .search_start
    );

    // symbol store.
    hdc_item_memory u_items (
        .clk, .we(item_we), .waddr(item_waddr), .wdata(item_wdata),
        .raddr(item_raddr), .rdata(item_rdata)
    );

    hdc_encoder u_enc (
        .clk, .rst_n, .start(enc_start), .op(enc_op), .arg(cmd_arg), .shift(cmd_shift),
        .item_rdata, .item_raddr, .busy(enc_busy), .enc_value, .proto_we, .proto_idx
    );

    // output side, reads the accumulator directly.
    hdc_assoc_search u_search (
        .clk, .rst_n, .proto_we, .proto_idx, .enc_value, .start(search_start),
        .busy(search_busy), .best_class, .best_distance
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the hdc testbench with verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module hdc_tb -o hdc_sim \
    && ./obj_dir/hdc_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src.f
+incdir+hdl
hdl/hdc_bus_pkg.sv
hdl/hdc_core_pkg.sv
hdl/hdc_apb_regs.sv
hdl/hdc_item_memory.sv
hdl/hdc_encoder.sv
hdl/hdc_assoc_search.sv
hdl/hdc_top.sv
testbench/hdc_tb.sv

//--- testbench/hdc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_config.svh"

module hdc_tb;
    import hdc_bus_pkg::*;
    import hdc_core_pkg::*;

    // the whole run needs well under 1500 cycles, so this leaves ample headroom.
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // reference model of the item memory, accumulator and prototypes.
    hv_t       item_model [`HDC_ITEM_DEPTH];
    hv_t       acc_model;
    hv_t       proto_model [`HDC_CLASS_COUNT];
    item_idx_t syms [16];

    integer seed;
    int     cycles;
    int     err_count;
    int     check_count;
    int     test_count;
    int     failed_tests;
    int     test_err_start;
    string  cur_test;

    hdc_top UUT (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit.
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // apb driver.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // called on a falling edge and returns on a falling edge.
    // stalls counts access cycles spent with pready low.
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic resp, output int stalls);
        stalls  = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
            stalls++;
        end
        resp = pslverr;
        // transfer completes on the rising edge in between.
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic resp);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
        end
        data = prdata;
        resp = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare and bookkeeping.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_error(input string msg);
        err_count++;
        $display("ERROR %s: %s", cur_test, msg);
    endtask

    task automatic check_hv(input string what, input hv_t exp, input hv_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_class(input string what, input class_idx_t exp, input class_idx_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAILED %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_distance(input string what, input distance_t exp,
                                  input distance_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAILED %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_resp(input string what, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAILED %s %s pslverr: expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        test_count++;
        if (err_count == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", cur_test, err_count - test_err_start);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one bit position per step with the lsb wrapping to the top.
    function automatic hv_t rotate_right(hv_t v, shift_t s);
        hv_t r;
        r = v;
        for (int i = 0; i < int'(s); i++) begin
            r = {r[0], r[`HDC_HV_WIDTH-1:1]};
        end
        return r;
    endfunction

    // nearest prototype by an upward scan so a tie keeps the lower index.
    task automatic expected_search(output class_idx_t bc, output distance_t bd);
        int d;
        int best;
        best = `HDC_HV_WIDTH + 1;
        bc   = '0;
        for (int c = 0; c < `HDC_CLASS_COUNT; c++) begin
            d = $countones(acc_model ^ proto_model[c]);
            if (d < best) begin
                best = d;
                bc   = class_idx_t'(c);
            end
        end
        bd = distance_t'(best);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic resp;
        int   stalls;
        apb_write(addr, data, resp, stalls);
        check_resp("register write", 1'b0, resp);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic resp;
        apb_read(addr, data, resp);
        check_resp("register read", 1'b0, resp);
    endtask

    // polls status until both engines are idle.
    task automatic wait_idle();
        logic [31:0] status;
        status = 32'h1;
        while (status[0]) begin
            read_reg(REG_STATUS, status);
        end
    endtask

    task automatic write_item(input item_idx_t idx, input hv_t value);
        write_reg(REG_ITEM_DATA, value);
        write_reg(REG_ARG, 32'(idx));
        write_reg(REG_CMD, 32'(OP_GEN_ITEM));
        item_model[idx] = value;
    endtask

    // issues one command, waits for it and updates the model.
    task automatic do_cmd(input hdc_op_e op, input int arg, input shift_t sh);
        write_reg(REG_ARG, 32'(arg));
        write_reg(REG_SHIFT, 32'(sh));
        write_reg(REG_CMD, 32'(op));
        wait_idle();
        case (op)
            OP_CLEAR:       acc_model = '0;
            OP_LOAD:        acc_model = item_model[arg];
            OP_BIND:        acc_model = acc_model ^ rotate_right(item_model[arg], sh);
            OP_STORE_CLASS: proto_model[arg] = acc_model;
            default:        ;
        endcase
    endtask

    task automatic check_enc(input string what);
        logic [31:0] data;
        read_reg(REG_ENC, data);
        check_hv(what, acc_model, data);
    endtask

    task automatic query_and_check(input string what);
        class_idx_t  bc;
        distance_t   bd;
        logic [31:0] data;
        expected_search(bc, bd);
        do_cmd(OP_QUERY, 0, 0);
        read_reg(REG_RESULT, data);
        check_class({what, " class"}, bc, data[1:0]);
        check_distance({what, " distance"}, bd, data[13:8]);
    endtask

    // a rejected command must flag pslverr.
    task automatic reject_cmd(input string what, input int arg, input logic [31:0] cmd);
        logic resp;
        int   stalls;
        write_reg(REG_ARG, 32'(arg));
        apb_write(REG_CMD, cmd, resp, stalls);
        check_resp(what, 1'b1, resp);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset_values();
        logic [31:0] data;
        logic        resp;
        int          stalls;
        begin_test("reset_values");
        read_reg(REG_ENC, data);
        check_hv("enc", '0, data);
        read_reg(REG_RESULT, data);
        check_class("result class", '0, data[1:0]);
        check_distance("result distance", '0, data[13:8]);
        read_reg(REG_STATUS, data);
        if (data[0]) begin
            report_error("status shows busy after reset");
        end
        apb_read(8'h20, data, resp);
        check_resp("unmapped read", 1'b1, resp);
        apb_write(8'h3C, 32'h1234, resp, stalls);
        check_resp("unmapped write", 1'b1, resp);
        apb_write(REG_ENC, 32'hffff, resp, stalls);
        check_resp("read-only write", 1'b1, resp);
        end_test();
    endtask

    task automatic test_items_load();
        begin_test("items_load");
        // 17 is odd, so these 16 symbols are distinct.
        for (int i = 0; i < 16; i++) begin
            syms[i] = item_idx_t'(i * 17 + 3);
            write_item(syms[i], hv_t'($random(seed)));
        end
        for (int i = 0; i < 16; i++) begin
            do_cmd(OP_LOAD, syms[i], 0);
            check_enc("enc after load");
        end
        end_test();
    endtask

    task automatic test_bind_chain();
        logic [31:0] pick;
        shift_t      sh;
        begin_test("bind_chain");
        do_cmd(OP_CLEAR, 0, 0);
        check_enc("enc after clear");
        for (int k = 0; k < 12; k++) begin
            pick = $random(seed);
            // edge shifts first and random ones after.
            if (k == 0) begin
                sh = 5'd0;
            end else if (k == 1) begin
                sh = 5'd31;
            end else begin
                sh = pick[8:4];
            end
            do_cmd(OP_BIND, syms[pick[3:0]], sh);
            check_enc("enc after bind");
        end
        end_test();
    endtask

    task automatic test_class_query();
        begin_test("class_query");
        for (int c = 0; c < `HDC_CLASS_COUNT; c++) begin
            do_cmd(OP_CLEAR, 0, 0);
            do_cmd(OP_LOAD, syms[c], 0);
            do_cmd(OP_BIND, syms[c + 4], shift_t'(c * 7 + 1));
            do_cmd(OP_STORE_CLASS, c, 0);
        end
        // rebuild class 2 and then move it away a little.
        do_cmd(OP_LOAD, syms[2], 0);
        do_cmd(OP_BIND, syms[6], 5'd15);
        do_cmd(OP_BIND, syms[9], 5'd3);
        query_and_check("perturbed");
        // class 3 becomes a copy of class 1 so the tie goes to 1.
        do_cmd(OP_LOAD, syms[1], 0);
        do_cmd(OP_BIND, syms[5], 5'd8);
        do_cmd(OP_STORE_CLASS, 3, 0);
        query_and_check("tie");
        end_test();
    endtask

    task automatic test_back_pressure();
        class_idx_t  bc;
        distance_t   bd;
        logic [31:0] data;
        logic        resp;
        int          stalls;
        begin_test("back_pressure");
        do_cmd(OP_LOAD, syms[3], 0);
        expected_search(bc, bd);
        apb_write(REG_CMD, 32'(OP_QUERY), resp, stalls);
        check_resp("query", 1'b0, resp);
        // straight behind the query while the scan still runs.
        apb_write(REG_CMD, 32'(OP_CLEAR), resp, stalls);
        check_resp("stalled clear", 1'b0, resp);
        if (stalls == 0) begin
            report_error("command write during a query was not stalled");
        end
        acc_model = '0;
        wait_idle();
        read_reg(REG_RESULT, data);
        check_class("query class", bc, data[1:0]);
        check_distance("query distance", bd, data[13:8]);
        check_enc("enc after stalled clear");
        // bad commands leave the accumulator alone.
        do_cmd(OP_LOAD, syms[7], 0);
        reject_cmd("load arg 256", 256, 32'(OP_LOAD));
        reject_cmd("bind arg 300", 300, 32'(OP_BIND));
        reject_cmd("store class 4", 4, 32'(OP_STORE_CLASS));
        reject_cmd("opcode 6", 0, 32'd6);
        reject_cmd("opcode 7", 0, 32'd7);
        read_reg(REG_STATUS, data);
        if (data[0]) begin
            report_error("a rejected command started an engine");
        end
        check_enc("enc after rejects");
        end_test();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed         = 32'hb3267d20;
        err_count    = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        acc_model    = '0;
        for (int c = 0; c < `HDC_CLASS_COUNT; c++) begin
            proto_model[c] = '0;
        end
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_values();
        test_items_load();
        test_bind_chain();
        test_class_query();
        test_back_pressure();

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
